//--- design/npc_buses.sv
// decoded instruction fields, idu to exu and gpr
interface npc_decode_if;
	import npc_pkg::*;

	opcode_t         op;
	logic [2:0]      func3;
	alu_op_t         alu_op;
	logic [4:0]      rd;
	logic [4:0]      rs1_addr;
	logic [4:0]      rs2_addr;
	// bit 0 reads rs1, bit 1 reads rs2
	logic [1:0]      ren;
	logic [XLEN-1:0] imm;

	modport idu (output op, func3, alu_op, rd, rs1_addr, rs2_addr, ren, imm);

	modport exu (input op, func3, alu_op, rd, rs1_addr, rs2_addr, ren, imm);

	modport gpr (input rs1_addr, rs2_addr, ren);

endinterface

// data memory access, exu to lsu
interface npc_mem_if;
	import npc_pkg::*;

	logic [XLEN-1:0] addr;
	logic [XLEN-1:0] wdata;
	logic            wen;
	// access size and load extension
	logic [2:0]      func3;
	logic [XLEN-1:0] rdata;

	modport exu (output addr, wdata, wen, func3, input rdata);

	modport lsu (input addr, wdata, wen, func3, output rdata);

endinterface

//--- design/npc_exu.sv
module npc_exu (
	input  logic [npc_pkg::XLEN-1:0] pc,
	npc_decode_if.exu                dec,
	input  logic [npc_pkg::XLEN-1:0] rs1_data,
	input  logic [npc_pkg::XLEN-1:0] rs2_data,
	npc_mem_if.exu                   mem,
	output logic [npc_pkg::XLEN-1:0] next_pc,
	output logic                     wb_en,
	output logic [4:0]               wb_addr,
	output logic [npc_pkg::XLEN-1:0] wb_data,
	output logic                     is_ebreak
);
	import npc_pkg::*;

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_res;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_target;
	logic            take;
	logic            writes_rd;

	//////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////

	// pc feeds auipc and jal, register otherwise
	assign op_a = (dec.op == op_auipc || dec.op == op_jal) ? pc : rs1_data;

	always_comb begin
		case (dec.op)
			op_r, op_branch: op_b = rs2_data;
			default:         op_b = dec.imm;
		endcase
	end

	always_comb begin
		case (dec.alu_op)
			alu_sub:  alu_res = op_a - op_b;
			alu_sll:  alu_res = op_a << op_b[4:0];
			alu_slt:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_sltu: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
			alu_xor:  alu_res = op_a ^ op_b;
			alu_srl:  alu_res = op_a >> op_b[4:0];
			alu_sra:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
			alu_or:   alu_res = op_a | op_b;
			alu_and:  alu_res = op_a & op_b;
			default:  alu_res = op_a + op_b;
		endcase
	end

	//////////////////////////////////////////////////
	// branch and next pc
	//////////////////////////////////////////////////

	always_comb begin
		case (dec.func3)
			3'b000:  take = rs1_data == rs2_data;
			3'b001:  take = rs1_data != rs2_data;
			3'b100:  take = $signed(rs1_data) < $signed(rs2_data);
			3'b101:  take = $signed(rs1_data) >= $signed(rs2_data);
			3'b110:  take = rs1_data < rs2_data;
			3'b111:  take = rs1_data >= rs2_data;
			default: take = 1'b0;
		endcase
	end

	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + dec.imm;

	always_comb begin
		case (dec.op)
			op_jal:    next_pc = pc_target;
			op_jalr:   next_pc = {alu_res[XLEN-1:1], 1'b0};
			op_branch: next_pc = take ? pc_target : pc_plus4;
			default:   next_pc = pc_plus4;
		endcase
	end

	//////////////////////////////////////////////////
	// memory, write-back, halt
	//////////////////////////////////////////////////

	assign mem.addr  = alu_res;
	assign mem.wdata = rs2_data;
	assign mem.wen   = dec.op == op_store;
	assign mem.func3 = dec.func3;

	always_comb begin
		writes_rd = 1'b1;
		case (dec.op)
			op_jal, op_jalr: wb_data = pc_plus4;
			op_load:         wb_data = mem.rdata;
			op_r, op_i, op_lui, op_auipc: wb_data = alu_res;
			default: begin
				wb_data   = '0;
				writes_rd = 1'b0;
			end
		endcase
	end

	// rd of x0 counts as no write
	assign wb_en   = writes_rd && dec.rd != 5'd0;
	assign wb_addr = dec.rd;

	assign is_ebreak = dec.op == op_system && dec.func3 == 3'b000 &&
		dec.imm[11:0] == EBREAK_WORD[31:20] && dec.rs1_addr == 5'd0 && dec.rd == 5'd0;

endmodule

//--- design/npc_gpr.sv
module npc_gpr (
	input  logic                     clk,
	input  logic                     rst,
	npc_decode_if.gpr                dec,
	input  logic                     wb_en,
	input  logic [4:0]               wb_addr,
	input  logic [npc_pkg::XLEN-1:0] wb_data,
	output logic [npc_pkg::XLEN-1:0] rs1_data,
	output logic [npc_pkg::XLEN-1:0] rs2_data
);
	import npc_pkg::*;

	logic [XLEN-1:0] regs [32];

	// single write port, x0 never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && wb_addr != 5'd0) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// two read ports
	// zero when disabled or addressing x0
	always_comb begin
		rs1_data = '0;
		rs2_data = '0;
		if (dec.ren[0] && dec.rs1_addr != 5'd0) begin
			rs1_data = regs[dec.rs1_addr];
		end
		if (dec.ren[1] && dec.rs2_addr != 5'd0) begin
			rs2_data = regs[dec.rs2_addr];
		end
	end

endmodule

//--- design/npc_idu.sv
module npc_idu (
	input  logic [npc_pkg::XLEN-1:0] inst,
	npc_decode_if.idu                dec
);
	import npc_pkg::*;

	opcode_t         op;
	logic [2:0]      raw_func3;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;

	// fixed fields
	assign op        = opcode_t'(inst[6:0]);
	assign raw_func3 = inst[14:12];

	assign dec.op       = op;
	assign dec.rd       = inst[11:7];
	assign dec.rs1_addr = inst[19:15];
	assign dec.rs2_addr = inst[24:20];

	// upper-immediate and jal formats carry no func3
	always_comb begin
		case (op)
			op_auipc, op_jal: dec.func3 = 3'b000;
			default:          dec.func3 = raw_func3;
		endcase
	end

	//////////////////////////////////////////////////
	// immediates
	//////////////////////////////////////////////////

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (op)
			op_i, op_load, op_jalr, op_system: dec.imm = imm_i;
			op_store:                          dec.imm = imm_s;
			op_branch:                         dec.imm = imm_b;
			op_lui, op_auipc:                  dec.imm = imm_u;
			op_jal:                            dec.imm = imm_j;
			default:                           dec.imm = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// register read enables
	//////////////////////////////////////////////////

	always_comb begin
		case (op)
			op_r, op_store, op_branch: dec.ren = 2'b11;
			op_i, op_load, op_jalr:    dec.ren = 2'b01;
			default:                   dec.ren = 2'b00;
		endcase
	end

	//////////////////////////////////////////////////
	// alu operation
	//////////////////////////////////////////////////

	// bit 30 picks sub and sra, sub only for the register form
	always_comb begin
		dec.alu_op = alu_add;
		if (op == op_r || op == op_i) begin
			case (raw_func3)
				3'b000: dec.alu_op = (op == op_r && inst[30]) ? alu_sub : alu_add;
				3'b001: dec.alu_op = alu_sll;
				3'b010: dec.alu_op = alu_slt;
				3'b011: dec.alu_op = alu_sltu;
				3'b100: dec.alu_op = alu_xor;
				3'b101: dec.alu_op = inst[30] ? alu_sra : alu_srl;
				3'b110: dec.alu_op = alu_or;
				default: dec.alu_op = alu_and;
			endcase
		end
	end

endmodule

//--- design/npc_ifu.sv
module npc_ifu (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         run,
	input  logic                         halt,
	input  logic                         prog_we,
	input  logic [npc_pkg::IMEM_AW-1:0]  prog_addr,
	input  logic [npc_pkg::XLEN-1:0]     prog_data,
	input  logic [npc_pkg::XLEN-1:0]     next_pc,
	output logic [npc_pkg::XLEN-1:0]     pc,
	output logic [npc_pkg::XLEN-1:0]     inst
);
	import npc_pkg::*;

	logic [XLEN-1:0]    imem [IMEM_WORDS];
	logic [IMEM_AW-1:0] fetch_idx;

	//////////////////////////////////////////////////
	// program counter
	//////////////////////////////////////////////////

	// advances once per committed instruction
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (run && !halt) begin
			pc <= next_pc;
		end
	end

	//////////////////////////////////////////////////
	// instruction memory
	//////////////////////////////////////////////////

	// loaded from outside only while the core is idle
	always_ff @(posedge clk) begin
		if (prog_we && !run) begin
			imem[prog_addr] <= prog_data;
		end
	end

	// word index, wraps at the memory size
	assign fetch_idx = pc[IMEM_AW+1:2];

	// asynchronous read
	assign inst = imem[fetch_idx];

endmodule

//--- design/npc_lsu.sv
module npc_lsu (
	input logic    clk,
	npc_mem_if.lsu mem
);
	import npc_pkg::*;

	logic [XLEN-1:0]    dmem [DMEM_WORDS];
	logic [DMEM_AW-1:0] word_idx;
	logic [1:0]         lane;
	logic [XLEN-1:0]    cur_word;
	logic [XLEN-1:0]    merged;
	logic [7:0]         byte_sel;
	logic [15:0]        half_sel;

	// word index wraps modulo the memory depth
	assign word_idx = mem.addr[DMEM_AW+1:2];
	assign lane     = mem.addr[1:0];
	assign cur_word = dmem[word_idx];

	//////////////////////////////////////////////////
	// store merge
	//////////////////////////////////////////////////

	// halves are forced to their natural alignment
	always_comb begin
		merged = cur_word;
		case (mem.func3[1:0])
			2'b00:   merged[{lane, 3'b000} +: 8] = mem.wdata[7:0];
			2'b01:   merged[{lane[1], 4'b0000} +: 16] = mem.wdata[15:0];
			default: merged = mem.wdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (mem.wen) begin
			dmem[word_idx] <= merged;
		end
	end

	//////////////////////////////////////////////////
	// load extension
	//////////////////////////////////////////////////

	assign byte_sel = cur_word[{lane, 3'b000} +: 8];
	assign half_sel = cur_word[{lane[1], 4'b0000} +: 16];

	always_comb begin
		case (mem.func3)
			3'b000:  mem.rdata = {{24{byte_sel[7]}}, byte_sel};
			3'b001:  mem.rdata = {{16{half_sel[15]}}, half_sel};
			3'b100:  mem.rdata = {24'b0, byte_sel};
			3'b101:  mem.rdata = {16'b0, half_sel};
			default: mem.rdata = cur_word;
		endcase
	end

endmodule

//--- design/npc_pkg.sv
package npc_pkg;

	//////////////////////////////////////////////////
	// widths and memory sizes
	//////////////////////////////////////////////////

	localparam int XLEN = 32;

	// word-organized memories, 1 KiB each
	localparam int IMEM_WORDS = 256;
	localparam int IMEM_AW    = 8;
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW    = 8;

	// ebreak as the halt instruction
	localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

	//////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////

	// rv32i major opcodes
	typedef enum logic [6:0] {
		op_r      = 7'b0110011,
		op_i      = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_system = 7'b1110011
	} opcode_t;

	// alu operations
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_t;

endpackage

//--- design/npc_top.sv
module npc_top (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         run,
	input  logic                         prog_we,
	input  logic [npc_pkg::IMEM_AW-1:0]  prog_addr,
	input  logic [npc_pkg::XLEN-1:0]     prog_data,
	output logic                         halt,
	output logic                         commit_valid,
	output logic [npc_pkg::XLEN-1:0]     commit_pc,
	output logic [4:0]                   commit_rd,
	output logic [npc_pkg::XLEN-1:0]     commit_data
);
	import npc_pkg::*;

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] inst;
	logic [XLEN-1:0] exec_inst;
	logic [XLEN-1:0] next_pc;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic            wb_en;
	logic [4:0]      wb_addr;
	logic [XLEN-1:0] wb_data;
	logic            is_ebreak;

	npc_decode_if dec_bus ();
	npc_mem_if    mem_bus ();

	// one instruction per cycle while running and out of reset
	assign commit_valid = run && !halt && !rst;

	// stalled cycles decode an all-zero word that writes nothing
	assign exec_inst = commit_valid ? inst : '0;

	npc_ifu i_ifu (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.halt      (halt),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.next_pc   (next_pc),
		.pc        (pc),
		.inst      (inst)
	);

	npc_idu i_idu (
		.inst (exec_inst),
		.dec  (dec_bus.idu)
	);

	npc_gpr i_gpr (
		.clk      (clk),
		.rst      (rst),
		.dec      (dec_bus.gpr),
		.wb_en    (wb_en),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	npc_exu i_exu (
		.pc        (pc),
		.dec       (dec_bus.exu),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.mem       (mem_bus.exu),
		.next_pc   (next_pc),
		.wb_en     (wb_en),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data),
		.is_ebreak (is_ebreak)
	);

	npc_lsu i_lsu (
		.clk (clk),
		.mem (mem_bus.lsu)
	);

	// sticky halt after ebreak commits
	always_ff @(posedge clk) begin
		if (rst) begin
			halt <= 1'b0;
		end else if (commit_valid && is_ebreak) begin
			halt <= 1'b1;
		end
	end

	assign commit_pc   = pc;
	assign commit_rd   = wb_en ? wb_addr : 5'd0;
	assign commit_data = wb_en ? wb_data : '0;

endmodule

//--- project.f
+incdir+tests
design/npc_pkg.sv
design/npc_buses.sv
design/npc_ifu.sv
design/npc_idu.sv
design/npc_gpr.sv
design/npc_exu.sv
design/npc_lsu.sv
design/npc_top.sv
tests/tb_npc_top.sv

//--- tests/tb_npc_ref.svh
`ifndef TB_NPC_REF_SVH
`define TB_NPC_REF_SVH

typedef struct packed {
	logic [XLEN-1:0] pc;
	logic [4:0]      rd;
	logic [XLEN-1:0] data;
} commit_t;

logic [31:0] lfsr = 32'd77660;
logic [31:0] prog [256];
int          prog_len;

// architectural state of the model
logic [31:0] model_regs [32];
logic [31:0] model_dmem [256];
logic [31:0] model_pc;
logic        model_halted;

//////////////////////////////////////////////////
// random source
//////////////////////////////////////////////////

// galois form, taps for x^32+x^22+x^2+x+1
function automatic logic lfsr_bit();
	logic out;
	out = lfsr[0];
	lfsr = lfsr >> 1;
	if (out) begin
		lfsr = lfsr ^ 32'h8020_0003;
	end
	return out;
endfunction

function automatic logic [31:0] take_bits(int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_bit()};
	end
	return v;
endfunction

//////////////////////////////////////////////////
// program generator
//////////////////////////////////////////////////

function automatic void push_inst(logic [31:0] w);
	prog[prog_len] = w;
	prog_len++;
endfunction

// kind 0 arith, 1 x0 targets, 2 control flow, 3 memory, 4 mixed
function automatic void gen_program(int kind, int body);
	int          last, k, sel;
	logic [2:0]  cls, f3;
	logic [4:0]  rd, rs1, rs2;
	logic [1:0]  lane;
	logic [11:0] imm;
	logic [12:0] boff;
	logic [20:0] joff;
	prog_len = 0;
	last = 9 + body;
	// x31 is the data base, its window zeroed first
	push_inst({12'h100, 5'd0, 3'b000, 5'd31, 7'b0010011});
	for (int w = 0; w < 8; w++) begin
		imm = 12'(w * 4);
		push_inst({imm[11:5], 5'd0, 5'd31, 3'b010, imm[4:0], 7'b0100011});
	end
	for (int i = 0; i < body; i++) begin
		cls  = 3'(take_bits(3));
		rd   = 5'd1 + 5'(take_bits(3) % 7);
		rs1  = 5'(take_bits(3));
		rs2  = 5'(take_bits(3));
		f3   = 3'(take_bits(3));
		lane = 2'(take_bits(2));
		imm  = 12'(take_bits(12));
		// forward only, never past the final ebreak
		k = 1 + int'(take_bits(2));
		if (prog_len + k > last) begin
			k = last - prog_len;
		end
		case (kind)
			0, 1:    sel = cls % 4;
			2:       sel = (cls < 6) ? 4 + cls % 3 : 1;
			3:       sel = (cls < 3) ? 7 : ((cls < 6) ? 8 : 1);
			default: sel = int'(take_bits(4)) % 9;
		endcase
		if (kind == 1 && lfsr_bit()) begin
			rd = 5'd0;
		end
		boff = 13'(k * 4);
		joff = 21'(k * 4);
		case (sel)
			0: push_inst({1'b0, (f3 == 3'b000 || f3 == 3'b101) && imm[0], 5'b0,
				rs2, rs1, f3, rd, 7'b0110011});
			1: begin
				// shift immediates keep only shamt and bit 30
				if (f3[1:0] == 2'b01) begin
					imm[11:5] = (f3 == 3'b101) ? {1'b0, imm[10], 5'b0} : 7'b0;
				end
				push_inst({imm, rs1, f3, rd, 7'b0010011});
			end
			2, 3: push_inst({imm, f3, rs1, rd, (sel == 2) ? 7'b0110111 : 7'b0010111});
			4: begin
				if (f3[2:1] == 2'b01) begin
					f3[2] = 1'b1;
				end
				push_inst({boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11],
					7'b1100011});
			end
			5: push_inst({joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111});
			6: begin
				imm = 12'((prog_len + k) * 4);
				push_inst({imm, 5'd0, 3'b000, rd, 7'b1100111});
			end
			default: begin
				if (sel == 7) begin
					f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
				end else if (f3[1:0] == 2'b11 || f3 == 3'b110) begin
					f3 = 3'b010;
				end
				// natural alignment inside the 32-byte window
				lane = (f3[1:0] == 2'b10) ? 2'b00 :
					((f3[1:0] == 2'b01) ? {lane[1], 1'b0} : lane);
				imm = {7'b0, imm[2:0], lane};
				if (sel == 7) begin
					push_inst({imm[11:5], rs2, 5'd31, f3, imm[4:0], 7'b0100011});
				end else begin
					push_inst({imm, 5'd31, f3, rd, 7'b0000011});
				end
			end
		endcase
	end
	push_inst(EBREAK_WORD);
endfunction

//////////////////////////////////////////////////
// instruction-set model
//////////////////////////////////////////////////

function automatic void reset_model();
	model_pc = '0;
	model_halted = 1'b0;
	for (int r = 0; r < 32; r++) begin
		model_regs[r] = '0;
	end
endfunction

function automatic logic [31:0] alu_result(logic [2:0] f3, logic alt,
	logic [31:0] a, logic [31:0] b);
	case (f3)
		3'b000: return alt ? a - b : a + b;
		3'b001: return a << b[4:0];
		3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'b011: return (a < b) ? 32'd1 : 32'd0;
		3'b100: return a ^ b;
		3'b101: begin
			if (alt) begin
				return $unsigned($signed(a) >>> b[4:0]);
			end
			return a >> b[4:0];
		end
		3'b110: return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
	case (f3)
		3'b000: return a == b;
		3'b001: return a != b;
		3'b100: return $signed(a) < $signed(b);
		3'b101: return $signed(a) >= $signed(b);
		3'b110: return a < b;
		default: return a >= b;
	endcase
endfunction

// executes the instruction at model_pc, returns its commit
function automatic commit_t ref_step();
	commit_t     c;
	logic [31:0] inst, a, b, imm_i, imm_s, imm_b, imm_j;
	logic [31:0] addr, word, lo_b, lo_h, res, nxt;
	logic        wr;
	logic [4:0]  rd;
	logic [2:0]  f3;
	inst  = prog[model_pc[9:2]];
	rd    = inst[11:7];
	f3    = inst[14:12];
	a     = model_regs[inst[19:15]];
	b     = model_regs[inst[24:20]];
	imm_i = {{20{inst[31]}}, inst[31:20]};
	imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	res   = '0;
	wr    = 1'b1;
	nxt   = model_pc + 4;
	addr  = a + ((inst[6:0] == 7'b0100011) ? imm_s : imm_i);
	word  = model_dmem[addr[9:2]];
	lo_b  = word >> (addr[1:0] * 8);
	lo_h  = word >> (addr[1] * 16);
	case (inst[6:0])
		7'b0110111: res = {inst[31:12], 12'b0};
		7'b0010111: res = model_pc + {inst[31:12], 12'b0};
		7'b1101111: begin
			res = model_pc + 4;
			nxt = model_pc + imm_j;
		end
		7'b1100111: begin
			res = model_pc + 4;
			nxt = (a + imm_i) & ~32'd1;
		end
		7'b1100011: begin
			wr = 1'b0;
			if (branch_taken(f3, a, b)) begin
				nxt = model_pc + imm_b;
			end
		end
		7'b0000011: begin
			case (f3)
				3'b000:  res = {{24{lo_b[7]}}, lo_b[7:0]};
				3'b001:  res = {{16{lo_h[15]}}, lo_h[15:0]};
				3'b100:  res = {24'b0, lo_b[7:0]};
				3'b101:  res = {16'b0, lo_h[15:0]};
				default: res = word;
			endcase
		end
		7'b0100011: begin
			wr = 1'b0;
			case (f3)
				3'b000:  word[addr[1:0] * 8 +: 8] = b[7:0];
				3'b001:  word[addr[1] * 16 +: 16] = b[15:0];
				default: word = b;
			endcase
			model_dmem[addr[9:2]] = word;
		end
		7'b0010011: res = alu_result(f3, (f3 == 3'b101) && inst[30], a, imm_i);
		7'b0110011: res = alu_result(f3, inst[30], a, b);
		default: begin
			// only ebreak reaches here
			wr = 1'b0;
			model_halted = 1'b1;
		end
	endcase
	if (wr && rd != 5'd0) begin
		model_regs[rd] = res;
	end
	c.pc     = model_pc;
	c.rd     = (wr && rd != 5'd0) ? rd : 5'd0;
	c.data   = (wr && rd != 5'd0) ? res : '0;
	model_pc = nxt;
	return c;
endfunction

`endif

//--- tests/tb_npc_top.sv
module tb_npc_top;
	timeunit 1ns;
	timeprecision 1ps;

	import npc_pkg::*;

	logic               clk;
	logic               rst;
	logic               run;
	logic               prog_we;
	logic [IMEM_AW-1:0] prog_addr;
	logic [XLEN-1:0]    prog_data;
	logic               halt;
	logic               commit_valid;
	logic [XLEN-1:0]    commit_pc;
	logic [4:0]         commit_rd;
	logic [XLEN-1:0]    commit_data;

	int test_errs;
	int total_errs;
	int tests_run;
	int tests_failed;

	`include "tb_npc_ref.svh"

	npc_top i_npc_top (
		.clk          (clk),
		.rst          (rst),
		.run          (run),
		.prog_we      (prog_we),
		.prog_addr    (prog_addr),
		.prog_data    (prog_data),
		.halt         (halt),
		.commit_valid (commit_valid),
		.commit_pc    (commit_pc),
		.commit_rd    (commit_rd),
		.commit_data  (commit_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] want);
		if (got !== want) begin
			$display("MISMATCH at %0t ns: commit_pc %h, expected %h", $time, got, want);
			test_errs++;
		end
	endtask

	task automatic check_rd(input logic [4:0] got, input logic [4:0] want);
		if (got !== want) begin
			$display("MISMATCH at %0t ns: commit_rd %0d, expected %0d", $time, got, want);
			test_errs++;
		end
	endtask

	task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] want);
		if (got !== want) begin
			$display("MISMATCH at %0t ns: commit_data %h, expected %h", $time, got, want);
			test_errs++;
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	task automatic load_program();
		for (int k = 0; k < prog_len; k++) begin
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= IMEM_AW'(k);
			prog_data <= prog[k];
		end
		@(posedge clk);
		prog_we <= 1'b0;
	endtask

	task automatic reset_core();
		@(posedge clk);
		rst <= 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic pause_run(input int after, input int len);
		repeat (after) @(posedge clk);
		run <= 1'b0;
		repeat (len) @(posedge clk);
		run <= 1'b1;
	endtask

	// one commit per model step, sampled on the falling edge
	task automatic compare_commits(output int commits);
		commit_t want;
		int      waited;
		commits = 0;
		while (!model_halted) begin
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
				if (commit_valid && !run) begin
					$display("commit seen while run is low at %0t ns", $time);
					test_errs++;
				end
			end while (!commit_valid && waited < 50);
			if (!commit_valid) begin
				$display("no commit within 50 cycles, model pc %h", model_pc);
				test_errs++;
				return;
			end
			want = ref_step();
			check_pc(commit_pc, want.pc);
			check_rd(commit_rd, want.rd);
			check_data(commit_data, want.data);
			commits++;
		end
	endtask

	task automatic run_test(input string name, input int kind, input int body,
		input bit drop);
		int commits;
		int waited;
		test_errs = 0;
		gen_program(kind, body);
		load_program();
		reset_core();
		reset_model();
		@(posedge clk);
		run <= 1'b1;
		fork
			if (drop) pause_run(6, 4);
			compare_commits(commits);
		join
		if (model_halted && test_errs == 0) begin
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!halt && waited < 10);
			if (!halt) begin
				$display("halt did not rise after the EBREAK commit");
				test_errs++;
			end
			// the core must stay quiet while run is still high
			for (int c = 0; c < 20; c++) begin
				@(negedge clk);
				if (commit_valid) begin
					$display("commit_valid seen after halt at pc %h", commit_pc);
					test_errs++;
				end
			end
		end
		@(posedge clk);
		run <= 1'b0;
		tests_run++;
		total_errs += test_errs;
		if (test_errs != 0) begin
			tests_failed++;
		end
		$display("%-14s %s  commits %0d  errors %0d", name,
			(test_errs == 0) ? "ok" : "FAIL", commits, test_errs);
	endtask

	initial begin
		rst       = 1'b1;
		run       = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		run_test("arith", 0, 30, 1'b0);
		run_test("x0 writes", 1, 24, 1'b0);
		run_test("control flow", 2, 30, 1'b0);
		run_test("load store", 3, 30, 1'b0);
		run_test("ebreak halt", 4, 3, 1'b0);
		run_test("run pause", 4, 30, 1'b1);
		$display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
			tests_run - tests_failed, tests_failed, total_errs);
		if (tests_failed == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
